/* source/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // Line geometry
  localparam int LINE_WORDS       = 4;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_WORDS * 4);

  // Word 0 in the lowest bits
  typedef logic [LINE_WORDS*32-1:0] line_t;

  // APB port to core, one word
  typedef struct packed {
    logic  write;
    addr_t addr;
    word_t wdata;
  } cpu_req_t;

  // Core to memory, one line; addr has zero offset bits
  typedef struct packed {
    logic  write;
    addr_t addr;
    line_t wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    core_idle,
    core_lookup,
    core_write_back,
    core_refill,
    core_respond
  } core_state_t;

endpackage

`default_nettype wire

/* source/dcache_apb_port.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_apb_port (
  input  wire logic              CLK,
  input  wire logic              RESET,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire dcache_pkg::addr_t paddr,
  input  wire dcache_pkg::word_t pwdata,
  output logic                   pready,
  output logic                   pslverr,
  output dcache_pkg::word_t      prdata,
  output logic                   req_valid,
  output dcache_pkg::cpu_req_t   req,
  input  wire logic              req_done,
  input  wire dcache_pkg::word_t rdata
);

  typedef enum logic [1:0] {
    port_idle,
    port_busy,
    port_error
  } port_state_t;

  port_state_t state_q;
  logic        setup;
  logic        misaligned;
  logic        complete;

  assign setup      = psel && !penable;
  assign misaligned = paddr[1:0] != 2'b00;

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      state_q <= port_idle;
    end else begin
      case (state_q)
        port_idle:  if (setup) state_q <= misaligned ? port_error : port_busy;
        port_busy:  if (req_done) state_q <= port_idle;
        port_error: state_q <= port_idle;
        default:    state_q <= port_idle;
      endcase
    end
  end

  // Transfer is latched at setup and held until the core answers
  always_ff @(posedge CLK) begin
    if (state_q == port_idle && setup) begin
      req.write <= pwrite;
      req.addr  <= paddr;
      req.wdata <= pwdata;
    end
  end

  assign complete  = (state_q == port_busy) && req_done;
  assign req_valid = state_q == port_busy;
  assign pready    = complete || (state_q == port_error);
  assign pslverr   = state_q == port_error;
  assign prdata    = complete ? rdata : '0;

endmodule

`default_nettype wire

/* source/dcache_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_core #(
  parameter int NUM_SETS = 16
) (
  input  wire logic                 CLK,
  input  wire logic                 RESET,
  input  wire logic                 req_valid,
  input  wire dcache_pkg::cpu_req_t req,
  output logic                      req_done,
  output dcache_pkg::word_t         rdata,
  output logic                      mem_valid,
  output dcache_pkg::mem_req_t      mem_req,
  input  wire logic                 mem_done,
  input  wire dcache_pkg::line_t    mem_rdata
);

  localparam int INDEX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS   = 32 - INDEX_BITS - dcache_pkg::LINE_OFFSET_BITS;
  localparam int WSEL_BITS  = $clog2(dcache_pkg::LINE_WORDS);

  typedef logic [TAG_BITS-1:0]   tag_t;
  typedef logic [INDEX_BITS-1:0] index_t;
  typedef logic [WSEL_BITS-1:0]  wsel_t;

  tag_t                     tag_mem  [2][NUM_SETS];
  dcache_pkg::line_t        data_mem [2][NUM_SETS];
  logic [1:0][NUM_SETS-1:0] valid_q;
  logic [1:0][NUM_SETS-1:0] dirty_q;
  // Names the way to replace next
  logic [NUM_SETS-1:0]      lru_q;

  dcache_pkg::core_state_t state_q;
  dcache_pkg::word_t       rdata_q;
  logic                    victim_q;

  tag_t                 req_tag;
  index_t               req_index;
  wsel_t                req_wsel;
  logic                 hit0;
  logic                 hit1;
  logic                 hit_any;
  logic                 hit_way;
  logic                 lru_way;
  logic                 need_wb;
  dcache_pkg::line_t    hit_line;
  dcache_pkg::line_t    fill_line;
  dcache_pkg::mem_req_t wb_req;
  dcache_pkg::mem_req_t refill_req;

  function automatic dcache_pkg::line_t put_word(dcache_pkg::line_t line, wsel_t sel,
                                                 dcache_pkg::word_t word);
    dcache_pkg::line_t merged;
    merged = line;
    merged[sel*32 +: 32] = word;
    return merged;
  endfunction

  assign req_tag   = req.addr[31 -: TAG_BITS];
  assign req_index = req.addr[dcache_pkg::LINE_OFFSET_BITS +: INDEX_BITS];
  assign req_wsel  = req.addr[2 +: WSEL_BITS];

  assign hit0     = valid_q[0][req_index] && (tag_mem[0][req_index] == req_tag);
  assign hit1     = valid_q[1][req_index] && (tag_mem[1][req_index] == req_tag);
  assign hit_any  = hit0 || hit1;
  assign hit_way  = hit1;
  assign hit_line = data_mem[hit_way][req_index];

  assign lru_way = lru_q[req_index];
  assign need_wb = valid_q[lru_way][req_index] && dirty_q[lru_way][req_index];

  // Victim line goes back to its own address
  assign wb_req = '{write: 1'b1,
                    addr:  {tag_mem[lru_way][req_index], req_index,
                            dcache_pkg::LINE_OFFSET_BITS'(0)},
                    wdata: data_mem[lru_way][req_index]};
  assign refill_req = '{write: 1'b0,
                        addr:  {req_tag, req_index, dcache_pkg::LINE_OFFSET_BITS'(0)},
                        wdata: '0};

  assign fill_line = req.write ? put_word(mem_rdata, req_wsel, req.wdata) : mem_rdata;

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      state_q   <= dcache_pkg::core_idle;
      mem_valid <= 1'b0;
      valid_q   <= '0;
      dirty_q   <= '0;
      lru_q     <= '0;
    end else begin
      case (state_q)
        dcache_pkg::core_idle: begin
          if (req_valid) state_q <= dcache_pkg::core_lookup;
        end
        dcache_pkg::core_lookup: begin
          if (hit_any) begin
            lru_q[req_index] <= ~hit_way;
            if (req.write) dirty_q[hit_way][req_index] <= 1'b1;
            state_q <= dcache_pkg::core_respond;
          end else begin
            mem_valid <= 1'b1;
            state_q   <= need_wb ? dcache_pkg::core_write_back : dcache_pkg::core_refill;
          end
        end
        dcache_pkg::core_write_back: begin
          if (mem_done) begin
            mem_valid <= 1'b0;
            state_q   <= dcache_pkg::core_refill;
          end
        end
        dcache_pkg::core_refill: begin
          // Re-raise after the gap that follows a write-back
          if (!mem_valid) begin
            mem_valid <= 1'b1;
          end else if (mem_done) begin
            mem_valid                    <= 1'b0;
            valid_q[victim_q][req_index] <= 1'b1;
            dirty_q[victim_q][req_index] <= req.write;
            lru_q[req_index]             <= ~victim_q;
            state_q                      <= dcache_pkg::core_respond;
          end
        end
        dcache_pkg::core_respond: state_q <= dcache_pkg::core_idle;
        default: state_q <= dcache_pkg::core_idle;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state_q == dcache_pkg::core_lookup) begin
      if (hit_any) begin
        rdata_q <= hit_line[req_wsel*32 +: 32];
        if (req.write) data_mem[hit_way][req_index] <= put_word(hit_line, req_wsel, req.wdata);
      end else begin
        victim_q <= lru_way;
        mem_req  <= need_wb ? wb_req : refill_req;
      end
    end
    if (state_q == dcache_pkg::core_write_back && mem_done) mem_req <= refill_req;
    if (state_q == dcache_pkg::core_refill && mem_valid && mem_done) begin
      data_mem[victim_q][req_index] <= fill_line;
      tag_mem[victim_q][req_index]  <= req_tag;
      rdata_q                       <= mem_rdata[req_wsel*32 +: 32];
    end
  end

  assign req_done = state_q == dcache_pkg::core_respond;
  assign rdata    = rdata_q;

endmodule

`default_nettype wire

/* source/main_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module main_memory #(
  parameter int MEM_LATENCY = 10,
  parameter int MEM_LINES   = 64
) (
  input  wire logic                 CLK,
  input  wire logic                 RESET,
  input  wire logic                 mem_valid,
  input  wire dcache_pkg::mem_req_t mem_req,
  output logic                      mem_done,
  output dcache_pkg::line_t         mem_rdata
);

  localparam int IDX_BITS = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  dcache_pkg::line_t   mem_q [MEM_LINES];
  logic                busy_q;
  logic [CNT_BITS-1:0] count_q;
  logic [IDX_BITS-1:0] line_idx;

  // Addresses alias every MEM_LINES lines
  assign line_idx = IDX_BITS'(mem_req.addr[31:dcache_pkg::LINE_OFFSET_BITS] % MEM_LINES);

  initial begin
    for (int i = 0; i < MEM_LINES; i++) begin
      mem_q[i] = '0;
    end
  end

  // Count runs down to zero, done falls in the cycle count hits zero
  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (busy_q) begin
      if (count_q == '0) busy_q <= 1'b0;
      else count_q <= count_q - 1'b1;
    end else if (mem_valid) begin
      busy_q  <= 1'b1;
      count_q <= CNT_BITS'(MEM_LATENCY - 1);
    end
  end

  assign mem_done = busy_q && (count_q == '0);

  always_ff @(posedge CLK) begin
    if (mem_done && mem_req.write) mem_q[line_idx] <= mem_req.wdata;
  end

  assign mem_rdata = mem_q[line_idx];

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top #(
  parameter int NUM_SETS    = 16,
  parameter int MEM_LATENCY = 10,
  parameter int MEM_LINES   = 64
) (
  input  wire logic              CLK,
  input  wire logic              RESET,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire dcache_pkg::addr_t paddr,
  input  wire dcache_pkg::word_t pwdata,
  output logic                   pready,
  output logic                   pslverr,
  output dcache_pkg::word_t      prdata
);

  logic                 req_valid;
  logic                 req_done;
  dcache_pkg::cpu_req_t req;
  dcache_pkg::word_t    rdata;
  logic                 mem_valid;
  logic                 mem_done;
  dcache_pkg::mem_req_t mem_req;
  dcache_pkg::line_t    mem_rdata;

  dcache_apb_port port_i (
    .CLK, .RESET, .psel, .penable, .pwrite, .paddr, .pwdata,
    .pready, .pslverr, .prdata, .req_valid, .req, .req_done, .rdata
  );

  dcache_core #(.NUM_SETS(NUM_SETS)) core_i (
    .CLK, .RESET, .req_valid, .req, .req_done, .rdata,
    .mem_valid, .mem_req, .mem_done, .mem_rdata
  );

  main_memory #(.MEM_LATENCY(MEM_LATENCY), .MEM_LINES(MEM_LINES)) memory_i (
    .CLK, .RESET, .mem_valid, .mem_req, .mem_done, .mem_rdata
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic CLK,
  output logic RESET
);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Held low over the first two rising edges
  initial begin
    RESET = 1'b0;
    repeat (2) @(posedge CLK);
    RESET <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/dcache_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_checker #(
  parameter int MEM_LINES = 64
) (
  input  wire logic              CLK,
  input  wire logic              RESET,
  input  wire logic              psel,
  input  wire logic              penable,
  input  wire logic              pwrite,
  input  wire dcache_pkg::addr_t paddr,
  input  wire dcache_pkg::word_t pwdata,
  input  wire logic              pready,
  input  wire logic              pslverr,
  input  wire dcache_pkg::word_t prdata,
  output int                     errors,
  output int                     checks
);

  // Above this the memory aliases
  localparam dcache_pkg::addr_t ADDR_LIMIT =
    dcache_pkg::addr_t'(MEM_LINES * dcache_pkg::LINE_WORDS * 4);

  dcache_pkg::word_t model [dcache_pkg::addr_t];
  int                error_count = 0;
  int                check_count = 0;

  // Last word written, zero if never written
  function automatic dcache_pkg::word_t expected_read(dcache_pkg::addr_t addr);
    if (model.exists(addr)) return model[addr];
    return '0;
  endfunction

  always @(negedge CLK) begin
    if (RESET && !psel && (pready || pslverr)) begin
      error_count++;
      $display("error at %0t ns: pready or pslverr high while psel is low", $time);
    end
    if (RESET && psel && penable && pready) begin
      check_count++;
      if (paddr[1:0] != 2'b00) begin
        if (!pslverr) begin
          error_count++;
          $display("error at %0t ns: misaligned access 0x%08h without pslverr", $time, paddr);
        end
      end else if (pslverr) begin
        error_count++;
        $display("error at %0t ns: aligned access 0x%08h with pslverr", $time, paddr);
      end else if (paddr < ADDR_LIMIT) begin
        if (pwrite) begin
          model[paddr] = pwdata;
        end else if (prdata != expected_read(paddr)) begin
          error_count++;
          $display("error at %0t ns: read 0x%08h gave 0x%08h, expected 0x%08h",
                   $time, paddr, prdata, expected_read(paddr));
        end
      end
    end
  end

  assign errors = error_count;
  assign checks = check_count;

endmodule

`default_nettype wire

/* verification/dcache_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_asserts (
  input wire logic                 CLK,
  input wire logic                 RESET,
  input wire logic                 psel,
  input wire logic                 penable,
  input wire logic                 req_valid,
  input wire logic                 req_done,
  input wire logic                 mem_valid,
  input wire logic                 mem_done,
  input wire logic                 pready,
  input wire logic                 pslverr,
  input wire dcache_pkg::mem_req_t mem_req
);

  // Memory request held until memory answers
  mem_req_stable: assert property (@(posedge CLK) disable iff (!RESET)
    (mem_valid && !mem_done) |=> $stable(mem_req))
    else $error("mem_req changed while waiting for mem_done");

  done_needs_valid: assert property (@(posedge CLK) disable iff (!RESET)
    req_done |-> req_valid)
    else $error("req_done without req_valid");

  // Error response only ends an access phase
  slverr_needs_ready: assert property (@(posedge CLK) disable iff (!RESET)
    pslverr |-> (pready && psel && penable))
    else $error("pslverr outside an access phase with pready");

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

  localparam int MEM_LINES  = 64;
  localparam int WAIT_LIMIT = 200;

  logic              CLK;
  logic              RESET;
  logic              psel;
  logic              penable;
  logic              pwrite;
  dcache_pkg::addr_t paddr;
  dcache_pkg::word_t pwdata;
  logic              pready;
  logic              pslverr;
  dcache_pkg::word_t prdata;
  int                errors;
  int                checks;
  int                errors_before;
  int                tests_done;
  int                tests_bad;
  logic              hung;
  logic [31:0]       rng;

  tb_clock clock_i (.CLK(CLK), .RESET(RESET));

  dcache_top #(.NUM_SETS(4), .MEM_LATENCY(10), .MEM_LINES(MEM_LINES)) dut_i (
    .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pready(pready), .pslverr(pslverr), .prdata(prdata)
  );

  dcache_checker #(.MEM_LINES(MEM_LINES)) checker_i (
    .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pready(pready), .pslverr(pslverr), .prdata(prdata),
    .errors(errors), .checks(checks)
  );

  bind dcache_top dcache_asserts asserts_i (
    .CLK(CLK), .RESET(RESET), .psel(psel), .penable(penable),
    .req_valid(req_valid), .req_done(req_done),
    .mem_valid(mem_valid), .mem_done(mem_done), .pready(pready), .pslverr(pslverr),
    .mem_req(mem_req)
  );

  function automatic logic [31:0] xorshift(logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Skipped once the bus has hung
  task automatic apb_transfer(input logic write, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t data);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    if (!hung) begin
      @(posedge CLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge CLK);
      penable <= 1'b1;
      while (!done && waited < WAIT_LIMIT) begin
        @(negedge CLK);
        done = pready;
        waited++;
      end
      @(posedge CLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      if (!done) begin
        hung = 1'b1;
        $display("timeout: no pready within %0d cycles for address 0x%08h", WAIT_LIMIT, addr);
      end
    end
  endtask

  task automatic finish_test(input int num, input string name);
    tests_done++;
    if (hung || errors != errors_before) begin
      tests_bad++;
      $display("test %0d %s: FAILED, %0d errors", num, name, errors - errors_before);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
    errors_before = errors;
  endtask

  initial begin
    int                waited;
    dcache_pkg::addr_t addr;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    hung = 1'b0;
    errors_before = 0;
    tests_done = 0;
    tests_bad = 0;
    rng = 32'hb0f39947;
    waited = 0;
    while (RESET !== 1'b1 && waited < 10) begin
      @(posedge CLK);
      waited++;
    end
    if (RESET !== 1'b1) begin
      hung = 1'b1;
      $display("reset was never released");
    end

    // Idle bus is watched by the checker meanwhile
    repeat (4) @(posedge CLK);
    apb_transfer(1'b0, 32'h100, '0);
    finish_test(1, "reset and cold miss");

    apb_transfer(1'b1, 32'h24, 32'hcafe_0001);
    apb_transfer(1'b0, 32'h24, '0);
    apb_transfer(1'b0, 32'h20, '0);
    apb_transfer(1'b0, 32'h28, '0);
    apb_transfer(1'b0, 32'h2c, '0);
    finish_test(2, "write then read line");

    // Set 0 with four sets of 16-byte lines
    apb_transfer(1'b1, 32'h204, 32'h3a3a_0001);
    apb_transfer(1'b1, 32'h244, 32'h3a3a_0002);
    apb_transfer(1'b1, 32'h284, 32'h3a3a_0003);
    apb_transfer(1'b0, 32'h204, '0);
    apb_transfer(1'b0, 32'h244, '0);
    apb_transfer(1'b0, 32'h284, '0);
    finish_test(3, "set conflict eviction");

    apb_transfer(1'b0, 32'h301, '0);
    apb_transfer(1'b1, 32'h206, 32'hdead_beef);
    apb_transfer(1'b0, 32'h204, '0);
    finish_test(4, "misaligned access");

    for (int i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      addr = {24'h0, rng[7:2], 2'b00};
      pwrite_pick: begin
        logic wr;
        wr = rng[31];
        rng = xorshift(rng);
        apb_transfer(wr, addr, rng);
      end
    end
    finish_test(5, "random traffic");

    $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
             tests_done, tests_bad, checks, errors);
    if (hung || errors != 0 || tests_bad != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache.f */
source/dcache_pkg.sv
source/dcache_apb_port.sv
source/dcache_core.sv
source/main_memory.sv
source/dcache_top.sv
verification/tb_clock.sv
verification/dcache_checker.sv
verification/dcache_asserts.sv
verification/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dcache_tb -f dcache.f \
  --Mdir obj_dir -o dcache_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
